// ==== branch_exec_top.f ====
design/rv_branch_pkg.sv
design/ex_operands_if.sv
design/redirect_if.sv
design/branch_alu.sv
design/branch_target_gen.sv
design/branch_ctrl_unit.sv
design/pc_unit.sv
design/branch_exec_top.sv
dv/branch_exec_asserts.sv
dv/tb_branch_exec_top.sv

// ==== dv/tb_branch_exec_top.sv ====
// Branch execute testbench
// Directed tests through the top level with a fetch PC model,
// results checked half a cycle after each capture edge
`timescale 1ns/1ps

module tb_branch_exec_top;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int TEST_STEPS    = 2 + 5 + 9 + 9 + 3 + 5 + 1;  // Steps per test plus final idle
    localparam int MARGIN_CYCLES = 20;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + TEST_STEPS + MARGIN_CYCLES) * CLK_PERIOD;
    localparam rv_branch_pkg::opcode_t OPCODE_ALU = 7'b0110011;  // R-type that never redirects

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_valid;
    rv_branch_pkg::opcode_t i_opcode;
    rv_branch_pkg::func3_t  i_func3;
    rv_branch_pkg::xlen_t   i_rs1, i_rs2, i_imm, i_pc;
    rv_branch_pkg::xlen_t   o_pc, o_link;
    logic                   o_flush, o_link_valid;

    // Model state for the outputs after the last capture edge
    rv_branch_pkg::xlen_t exp_pc, exp_link;
    logic                 exp_flush, exp_link_valid;
    string                exp_name;

    rv_branch_pkg::xlen_t lcg_state = 32'd50;  // Seed
    int                   check_count = 0;
    int                   error_count = 0;
    int                   assert_errors;

    branch_exec_top branch_exec_top_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_opcode     (i_opcode),
        .i_func3      (i_func3),
        .i_rs1        (i_rs1),
        .i_rs2        (i_rs2),
        .i_imm        (i_imm),
        .i_pc         (i_pc),
        .o_pc         (o_pc),
        .o_flush      (o_flush),
        .o_link       (o_link),
        .o_link_valid (o_link_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic rv_branch_pkg::xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sign-extended word-aligned offset of about 2 KiB either way
    function automatic rv_branch_pkg::xlen_t rand_imm();
        rv_branch_pkg::xlen_t r;
        r = lcg_next();
        return {{20{r[11]}}, r[11:2], 2'b00};
    endfunction

    // Branch condition straight from the ISA definition
    function automatic logic cond_met(rv_branch_pkg::func3_t f3,
                                      rv_branch_pkg::xlen_t a, rv_branch_pkg::xlen_t b);
        case (f3)
            rv_branch_pkg::FUNC3_BEQ:  return a == b;
            rv_branch_pkg::FUNC3_BNE:  return a != b;
            rv_branch_pkg::FUNC3_BLT:  return $signed(a) < $signed(b);
            rv_branch_pkg::FUNC3_BGE:  return $signed(a) >= $signed(b);
            rv_branch_pkg::FUNC3_BLTU: return a < b;
            rv_branch_pkg::FUNC3_BGEU: return a >= b;
            default:                   return 1'b0;  // Reserved encodings
        endcase
    endfunction

    task automatic check_xlen(input string test, input string sig,
                              input rv_branch_pkg::xlen_t expected,
                              input rv_branch_pkg::xlen_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test, sig, expected, actual);
        end
    endtask

    task automatic check_bit(input string test, input string sig,
                             input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %b actual %b", test, sig, expected, actual);
        end
    endtask

    // One cycle entered on a rising edge that drives, checks the last capture and steps the model
    task automatic step(input string name, input logic v, input rv_branch_pkg::opcode_t op,
                        input rv_branch_pkg::func3_t f3, input rv_branch_pkg::xlen_t a,
                        input rv_branch_pkg::xlen_t b, input rv_branch_pkg::xlen_t imm,
                        input rv_branch_pkg::xlen_t pc);
        logic                 is_jump;
        logic                 redirect;
        rv_branch_pkg::xlen_t target;
        i_valid  <= v;
        i_opcode <= op;
        i_func3  <= f3;
        i_rs1    <= a;
        i_rs2    <= b;
        i_imm    <= imm;
        i_pc     <= pc;
        is_jump  = v && (op == rv_branch_pkg::OPCODE_JAL || op == rv_branch_pkg::OPCODE_JALR);
        redirect = is_jump || (v && op == rv_branch_pkg::OPCODE_BRANCH && cond_met(f3, a, b));
        target   = (op == rv_branch_pkg::OPCODE_JALR) ? ((a + imm) & ~32'd1) : (pc + imm);
        @(negedge i_clk);  // Outputs settled
        check_xlen(exp_name, "o_pc", exp_pc, o_pc);
        check_bit(exp_name, "o_flush", exp_flush, o_flush);
        check_bit(exp_name, "o_link_valid", exp_link_valid, o_link_valid);
        check_xlen(exp_name, "o_link", exp_link, o_link);
        if (v) begin
            exp_pc = redirect ? target : exp_pc + 32'd4;
        end
        exp_flush      = redirect;
        exp_link_valid = is_jump;
        if (is_jump) begin
            exp_link = pc + 32'd4;  // Held until the next jump
        end
        exp_name = name;
        @(posedge i_clk);  // Capture edge
    endtask

    task automatic idle_step(input string name);
        step(name, 1'b0, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic test_reset_idle();
        // Would be taken if valid
        step("reset_idle", 1'b0, rv_branch_pkg::OPCODE_BRANCH, rv_branch_pkg::FUNC3_BEQ,
             32'h10, 32'h10, 32'h40, 32'h100);
        idle_step("reset_idle");
    endtask

    task automatic test_sequential();
        repeat (4) begin  // Back to back
            step("sequential", 1'b1, OPCODE_ALU, 3'b000, lcg_next(), lcg_next(),
                 rand_imm(), lcg_next() & ~32'd3);
        end
        idle_step("sequential");
    endtask

    task automatic test_beq_bne();
        rv_branch_pkg::xlen_t a, b, pc;
        repeat (2) begin
            a  = lcg_next();
            b  = a ^ (lcg_next() | 32'd1);  // Always differs from a
            pc = lcg_next() & ~32'd3;
            step("beq_equal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, rv_branch_pkg::FUNC3_BEQ,
                 a, a, rand_imm(), pc);
            step("beq_unequal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, rv_branch_pkg::FUNC3_BEQ,
                 a, b, rand_imm(), pc);
            step("bne_equal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, rv_branch_pkg::FUNC3_BNE,
                 a, a, rand_imm(), pc);
            step("bne_unequal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, rv_branch_pkg::FUNC3_BNE,
                 a, b, rand_imm(), pc);
        end
        idle_step("beq_bne");
    endtask

    task automatic test_compare();
        rv_branch_pkg::xlen_t  neg, pos;
        rv_branch_pkg::func3_t ops [4];
        ops[0] = rv_branch_pkg::FUNC3_BLT;
        ops[1] = rv_branch_pkg::FUNC3_BGE;
        ops[2] = rv_branch_pkg::FUNC3_BLTU;
        ops[3] = rv_branch_pkg::FUNC3_BGEU;
        neg = lcg_next() | 32'h8000_0000;  // Signed less but unsigned greater
        pos = lcg_next() & 32'h7fff_ffff;
        for (int i = 0; i < 4; i++) begin
            step("compare_neg_pos", 1'b1, rv_branch_pkg::OPCODE_BRANCH, ops[i],
                 neg, pos, rand_imm(), lcg_next() & ~32'd3);
            step("compare_pos_neg", 1'b1, rv_branch_pkg::OPCODE_BRANCH, ops[i],
                 pos, neg, rand_imm(), lcg_next() & ~32'd3);
        end
        idle_step("compare");
    endtask

    task automatic test_jumps();
        step("jal", 1'b1, rv_branch_pkg::OPCODE_JAL, 3'b000, lcg_next(), lcg_next(),
             rand_imm(), lcg_next() & ~32'd3);
        // Odd rs1 so the cleared bit 0 matters
        step("jalr", 1'b1, rv_branch_pkg::OPCODE_JALR, 3'b000, (lcg_next() & ~32'd3) | 32'd1,
             lcg_next(), rand_imm(), lcg_next() & ~32'd3);
        idle_step("jumps");
    endtask

    task automatic test_reserved_func3();
        rv_branch_pkg::xlen_t a;
        a = lcg_next();
        step("func3_010_equal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, 3'b010,
             a, a, rand_imm(), 32'h200);
        step("func3_010_unequal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, 3'b010,
             a, ~a, rand_imm(), 32'h204);
        step("func3_011_lt", 1'b1, rv_branch_pkg::OPCODE_BRANCH, 3'b011,
             32'h8000_0000, 32'h1, rand_imm(), 32'h208);
        step("func3_011_equal", 1'b1, rv_branch_pkg::OPCODE_BRANCH, 3'b011,
             a, a, rand_imm(), 32'h20c);
        idle_step("reserved_func3");
    endtask

    initial begin
        i_rst_n  <= 1'b0;
        i_valid  <= 1'b0;
        i_opcode <= '0;
        i_func3  <= '0;
        i_rs1    <= '0;
        i_rs2    <= '0;
        i_imm    <= '0;
        i_pc     <= '0;
        exp_pc         = rv_branch_pkg::RESET_PC;  // Values right after reset
        exp_link       = '0;
        exp_flush      = 1'b0;
        exp_link_valid = 1'b0;
        exp_name       = "reset";
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        test_reset_idle();
        test_sequential();
        test_beq_bne();
        test_compare();
        test_jumps();
        test_reserved_func3();
        idle_step("final");  // Checks the last idle cycle
        assert_errors = branch_exec_top_i.pc_unit_i.branch_exec_asserts_i.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== dv/branch_exec_asserts.sv ====
// Branch execute PC unit assertions
// Bound into the PC unit to watch the flush, link and alignment rules
`timescale 1ns/1ps

module branch_exec_asserts (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_valid,          // Instruction present
    input logic                 i_redirect,       // Flush request from the control unit
    input rv_branch_pkg::xlen_t i_branch_target,
    input rv_branch_pkg::xlen_t i_jump_target,
    input rv_branch_pkg::xlen_t i_fetch_pc,       // Registered fetch PC
    input logic                 i_flush,          // Registered flush pulse
    input logic                 i_link_valid
);

    int fail_count = 0;  // Failed assertions so far

    // An idle cycle never requests a redirect
    property p_no_redirect_when_idle;
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_valid |-> !i_redirect;
    endproperty

    // Link is only presented for jumps, which always flush
    property p_link_implies_flush;
        @(posedge i_clk) disable iff (!i_rst_n)
        i_link_valid |-> i_flush;
    endproperty

    // Aligned PC with aligned targets stays aligned
    property p_pc_stays_aligned;
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_fetch_pc[1:0] == 2'b00 && i_branch_target[1:0] == 2'b00 &&
         i_jump_target[1:0] == 2'b00) |=> (i_fetch_pc[1:0] == 2'b00);
    endproperty

    a_no_redirect_when_idle: assert property (p_no_redirect_when_idle)
        else begin
            $error("redirect requested on an invalid cycle");
            fail_count++;
        end
    a_link_implies_flush: assert property (p_link_implies_flush)
        else begin
            $error("o_link_valid high without o_flush");
            fail_count++;
        end
    a_pc_stays_aligned: assert property (p_pc_stays_aligned)
        else begin
            $error("o_pc lost word alignment with aligned targets");
            fail_count++;
        end

endmodule

bind pc_unit branch_exec_asserts branch_exec_asserts_i (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_valid         (i_valid),
    .i_redirect      (rdr.flush),
    .i_branch_target (rdr.branch_target),
    .i_jump_target   (rdr.jump_target),
    .i_fetch_pc      (o_pc),
    .i_flush         (o_flush),
    .i_link_valid    (o_link_valid)
);

// ==== design/branch_exec_top.sv ====
// Branch execute top level
// Compare ALU, target generator, branch control and PC unit joined
// through the operand and redirect bundles, plain ports outside
`timescale 1ns/1ps

module branch_exec_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    // Decoded instruction
    input  logic                   i_valid,
    input  rv_branch_pkg::opcode_t i_opcode,
    input  rv_branch_pkg::func3_t  i_func3,
    input  rv_branch_pkg::xlen_t   i_rs1,
    input  rv_branch_pkg::xlen_t   i_rs2,
    input  rv_branch_pkg::xlen_t   i_imm,
    input  rv_branch_pkg::xlen_t   i_pc,

    // Registered results
    output rv_branch_pkg::xlen_t   o_pc,
    output logic                   o_flush,
    output rv_branch_pkg::xlen_t   o_link,
    output logic                   o_link_valid
);

    ex_operands_if ops_if ();
    redirect_if    rdr_if ();

    rv_branch_pkg::xlen_t alu_result;  // ALU to control unit
    logic                 alu_zero;

    // Fill the operand bundle from the ports
    assign ops_if.valid  = i_valid;
    assign ops_if.opcode = i_opcode;
    assign ops_if.func3  = i_func3;
    assign ops_if.rs1    = i_rs1;
    assign ops_if.rs2    = i_rs2;
    assign ops_if.imm    = i_imm;
    assign ops_if.pc     = i_pc;

    branch_alu branch_alu_i (
        .ops      (ops_if.alu),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    branch_target_gen branch_target_gen_i (
        .ops (ops_if.tgt),
        .rdr (rdr_if.tgt)
    );

    branch_ctrl_unit branch_ctrl_unit_i (
        .ops          (ops_if.ctrl),
        .i_alu_result (alu_result),
        .i_alu_zero   (alu_zero),
        .rdr          (rdr_if.ctrl)
    );

    // Only registered stage in the block
    pc_unit pc_unit_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .rdr          (rdr_if.pc),
        .o_pc         (o_pc),
        .o_flush      (o_flush),
        .o_link       (o_link),
        .o_link_valid (o_link_valid)
    );

endmodule

// ==== design/pc_unit.sv ====
// Fetch PC unit
// Holds the fetch PC, loads the redirect target, and registers
// the flush pulse and the link value for JAL/JALR
`timescale 1ns/1ps

module pc_unit (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_valid,      // Instruction present
    redirect_if.pc               rdr,
    output rv_branch_pkg::xlen_t o_pc,         // Fetch PC
    output logic                 o_flush,      // One cycle per redirect
    output rv_branch_pkg::xlen_t o_link,       // pc + 4 of last jump
    output logic                 o_link_valid
);

    logic is_jump;

    assign is_jump = i_valid && (rdr.pc_src == rv_branch_pkg::PC_SRC_JUMP);

    // Fetch PC, held on invalid cycles
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_pc <= rv_branch_pkg::RESET_PC;
        end else if (i_valid) begin
            case (rdr.pc_src)
                rv_branch_pkg::PC_SRC_BRANCH: o_pc <= rdr.branch_target;
                rv_branch_pkg::PC_SRC_JUMP:   o_pc <= rdr.jump_target;
                default:                      o_pc <= o_pc + rv_branch_pkg::INSTR_BYTES;
            endcase
        end
    end

    // Flush and link strobes
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_flush      <= 1'b0;
            o_link       <= '0;
            o_link_valid <= 1'b0;
        end else begin
            o_flush      <= i_valid && rdr.flush;  // Low after an idle cycle
            o_link_valid <= is_jump;
            if (is_jump) begin
                o_link <= rdr.link;  // Kept until the next jump
            end
        end
    end

endmodule

// ==== design/branch_ctrl_unit.sv ====
// Branch control unit
// Picks the PC source from opcode, func3 and the ALU flags
// and raises flush on any redirect
`timescale 1ns/1ps

module branch_ctrl_unit (
    ex_operands_if.ctrl          ops,
    input  rv_branch_pkg::xlen_t i_alu_result,  // Bit 0 holds less-than
    input  logic                 i_alu_zero,    // Operands equal
    redirect_if.ctrl             rdr
);

    logic lt;     // Less-than from the ALU
    logic taken;  // Condition met for a branch

    assign lt = i_alu_result[0];

    // Condition per func3
    always_comb begin
        case (ops.func3)
            rv_branch_pkg::FUNC3_BEQ:  taken = i_alu_zero;
            rv_branch_pkg::FUNC3_BNE:  taken = !i_alu_zero;
            rv_branch_pkg::FUNC3_BLT:  taken = lt;
            rv_branch_pkg::FUNC3_BGE:  taken = !lt;
            rv_branch_pkg::FUNC3_BLTU: taken = lt;
            rv_branch_pkg::FUNC3_BGEU: taken = !lt;
            default:                   taken = 1'b0;  // 010, 011 never taken
        endcase
    end

    always_comb begin
        rdr.pc_src = rv_branch_pkg::PC_SRC_SEQ;  // Default PC + 4

        if (ops.valid) begin
            case (ops.opcode)
                rv_branch_pkg::OPCODE_BRANCH: begin
                    if (taken) begin
                        rdr.pc_src = rv_branch_pkg::PC_SRC_BRANCH;
                    end
                end
                rv_branch_pkg::OPCODE_JAL,
                rv_branch_pkg::OPCODE_JALR: begin
                    rdr.pc_src = rv_branch_pkg::PC_SRC_JUMP;  // Unconditional
                end
                default: begin
                    rdr.pc_src = rv_branch_pkg::PC_SRC_SEQ;
                end
            endcase
        end
    end

    // Any redirect kills the younger instructions
    assign rdr.flush = (rdr.pc_src != rv_branch_pkg::PC_SRC_SEQ);

endmodule

// ==== design/branch_target_gen.sv ====
// Branch and jump target generator
// Forms pc + imm, the JAL/JALR jump target and the pc + 4 link value
`timescale 1ns/1ps

module branch_target_gen (
    ex_operands_if.tgt ops,
    redirect_if.tgt    rdr
);

    rv_branch_pkg::xlen_t pc_rel;    // pc + imm
    rv_branch_pkg::xlen_t reg_rel;   // rs1 + imm
    logic                 is_jalr;

    assign pc_rel  = ops.pc + ops.imm;
    assign reg_rel = ops.rs1 + ops.imm;

    assign is_jalr = (ops.opcode == rv_branch_pkg::OPCODE_JALR);

    // Conditional branches are always PC relative
    assign rdr.branch_target = pc_rel;

    // JALR drops bit 0 of the sum, JAL stays PC relative
    always_comb begin
        if (is_jalr) begin
            rdr.jump_target = {reg_rel[rv_branch_pkg::XLEN-1:1], 1'b0};
        end else begin
            rdr.jump_target = pc_rel;
        end
    end

    // Return address written to rd
    assign rdr.link = ops.pc + rv_branch_pkg::INSTR_BYTES;

endmodule

// ==== design/branch_alu.sv ====
// Branch compare ALU
// One 33-bit subtraction gives the difference, the zero flag and
// both the signed and unsigned less-than results
`timescale 1ns/1ps

module branch_alu (
    ex_operands_if.alu           ops,
    output rv_branch_pkg::xlen_t o_result,  // Difference or less-than in bit 0
    output logic                 o_zero     // rs1 == rs2
);

    logic [rv_branch_pkg::XLEN:0] sub_ext;  // Borrow plus difference
    rv_branch_pkg::xlen_t         diff;
    logic                         lt_u;
    logic                         lt_s;
    logic                         sign_differs;

    // Zero-extend both operands so the top bit is the borrow
    assign sub_ext = {1'b0, ops.rs1} - {1'b0, ops.rs2};
    assign diff    = sub_ext[rv_branch_pkg::XLEN-1:0];

    assign o_zero = (diff == '0);

    // Borrow out means rs1 < rs2 unsigned
    assign lt_u = sub_ext[rv_branch_pkg::XLEN];

    // Opposite signs decide by rs1 sign alone, otherwise no overflow
    assign sign_differs = ops.rs1[rv_branch_pkg::XLEN-1] ^ ops.rs2[rv_branch_pkg::XLEN-1];
    assign lt_s = sign_differs ? ops.rs1[rv_branch_pkg::XLEN-1]
                               : diff[rv_branch_pkg::XLEN-1];

    always_comb begin
        case (ops.func3)
            rv_branch_pkg::FUNC3_BLT,
            rv_branch_pkg::FUNC3_BGE: begin
                o_result = {{(rv_branch_pkg::XLEN-1){1'b0}}, lt_s};  // Signed compare
            end
            rv_branch_pkg::FUNC3_BLTU,
            rv_branch_pkg::FUNC3_BGEU: begin
                o_result = {{(rv_branch_pkg::XLEN-1){1'b0}}, lt_u};  // Unsigned compare
            end
            default: begin
                o_result = diff;  // BEQ, BNE and the rest
            end
        endcase
    end

endmodule

// ==== design/redirect_if.sv ====
// Redirect bundle into the PC unit
// Decision from the control unit plus the candidate targets and link
`timescale 1ns/1ps

interface redirect_if;

    rv_branch_pkg::pc_src_t pc_src;         // Next PC selection
    logic                   flush;          // Redirect this cycle
    rv_branch_pkg::xlen_t   branch_target;  // pc + imm
    rv_branch_pkg::xlen_t   jump_target;    // JAL or JALR target
    rv_branch_pkg::xlen_t   link;           // pc + 4 for rd

    // Driven by the branch control unit
    modport ctrl (
        output pc_src, flush
    );

    // Driven by the target generator
    modport tgt (
        output branch_target, jump_target, link
    );

    // PC unit consumes everything
    modport pc (
        input pc_src, flush, branch_target, jump_target, link
    );

endinterface

// ==== design/ex_operands_if.sv ====
// Execute stage operand bundle
// Carries the decoded instruction fields to the compare ALU,
// the target generator and the branch control unit
`timescale 1ns/1ps

interface ex_operands_if;

    logic                 valid;   // Instruction present this cycle
    rv_branch_pkg::opcode_t opcode;
    rv_branch_pkg::func3_t  func3;
    rv_branch_pkg::xlen_t   rs1;     // First register operand
    rv_branch_pkg::xlen_t   rs2;     // Second register operand
    rv_branch_pkg::xlen_t   imm;     // Sign-extended immediate
    rv_branch_pkg::xlen_t   pc;      // PC of this instruction

    // Compare ALU side
    modport alu (
        input rs1, rs2, func3
    );

    // Target generator side
    modport tgt (
        input opcode, rs1, imm, pc
    );

    // Decision logic only needs the control fields
    modport ctrl (
        input valid, opcode, func3
    );

endinterface

// ==== design/rv_branch_pkg.sv ====
// RV32I branch resolution package
// Shared widths, field types, opcode and func3 codes, PC source codes
// and the fetch PC after reset
package rv_branch_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Operands, immediate, PCs, targets and link value
    typedef logic [XLEN-1:0] xlen_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;   // Bits 6:0 of the instruction
    typedef logic [2:0] func3_t;    // Bits 14:12 of the instruction

    // Next PC selection
    typedef logic [1:0] pc_src_t;

    // PC source codes
    localparam pc_src_t PC_SRC_SEQ    = 2'b00;  // PC + 4
    localparam pc_src_t PC_SRC_BRANCH = 2'b01;  // Taken conditional branch
    localparam pc_src_t PC_SRC_JUMP   = 2'b10;  // JAL or JALR

    // Control transfer opcodes
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;

    // Conditional branch func3 values
    localparam func3_t FUNC3_BEQ  = 3'b000;
    localparam func3_t FUNC3_BNE  = 3'b001;
    localparam func3_t FUNC3_BLT  = 3'b100;
    localparam func3_t FUNC3_BGE  = 3'b101;
    localparam func3_t FUNC3_BLTU = 3'b110;
    localparam func3_t FUNC3_BGEU = 3'b111;
    // 010 and 011 are unassigned for branches, never taken

    // Size of one instruction in bytes
    localparam xlen_t INSTR_BYTES = 32'd4;

    // Fetch PC after reset
    localparam xlen_t RESET_PC = 32'h0000_0000;

endpackage
